//--- run_sim.sh
#!/usr/bin/env bash
# builds the time tagger testbench with Verilator, runs it and searches the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_ttag_top -f ttag_top.f -o tb_ttag_top \
	&& ./obj_dir/tb_ttag_top | tee sim.log \
	|| { echo "verilator build or simulation run failed"; exit 1; }

grep -qx "TEST OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- tb_ttag_clkgen.sv
// testbench clock and reset source for the time tagger, instanced once by the top testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ttag_clkgen #(
	parameter real PERIOD_NS    = 40.0, // clock period
	parameter int  RESET_CYCLES = 8     // rising edges with reset held high
) (
	output logic clk_120m, // free-running clock
	output logic ttagres   // active-high reset
);

	initial begin
		clk_120m = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_120m = ~clk_120m;
	end

	initial begin
		ttagres = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_120m);
		@(negedge clk_120m); // release away from the sampling edge
		ttagres = 1'b0;
	end

endmodule

`default_nettype wire

//--- tb_ttag_top.sv
// testbench for ttag_top: drives pps, triggers and dead, checks captures, buffers and status flags
`timescale 1ns/1ps
`default_nettype none

module tb_ttag_top
	import ttag_time_pkg::*;
	import ttag_ctrl_pkg::*;
();

	localparam int NUM_SLOTS = 4;
	localparam int SLOT_W    = $clog2(NUM_SLOTS);

	logic              clk_120m;
	logic              ttagres;
	logic              pps, evtclkf, evtclks, dead;           // async event lines
	tag_t              evtcnt, evtcntm;                       // trigger tags
	logic [SLOT_W-1:0] address_wsb, address_rsb, address_wmb, address_rmb;
	status_vec_t       status_clr;
	ttag_word_t        teststatus, c120mout, c120calout, c120deadout;
	ttag_word_t        onanosec, oseconds, c120mout_sb, c120calout_sb;          // shower side
	ttag_word_t        slowtriggerns, slowtriggersec, c120mout_mb, c120calout_mb; // muon side

	integer     seed        = 32'hf53f_a269; // fixed seed for $random
	int         cycle_cnt   = 0;             // rising edges since time zero
	int         error_cnt   = 0;
	int         timeout_cnt = 0;
	int         pps_count   = 0;             // pps pulses driven so far
	ttag_word_t act_q[$];                    // pending compares, filled on the falling edge
	ttag_word_t exp_q[$];
	string      what_q[$];
	ttag_word_t chk_act, chk_exp;
	string      chk_what;

	tag_t       rec_tag  [2][NUM_SLOTS]; // [0] shower, [1] muon
	int         rec_cycle[2][NUM_SLOTS]; // cycle the trigger line went high
	ttag_word_t rec_sec  [2][NUM_SLOTS];
	ttag_word_t rec_mout [2][NUM_SLOTS];
	ttag_word_t rec_cal  [2][NUM_SLOTS];
	ttag_word_t ns_base  [2];            // ns word of the first slot, origin for the gaps
	logic       base_valid[2];

	tb_ttag_clkgen #(.PERIOD_NS(40.0), .RESET_CYCLES(8)) i_clkgen (
		.clk_120m(clk_120m), .ttagres(ttagres)
	);

	ttag_top #(.NUM_SLOTS(NUM_SLOTS)) i_dut (
		.clk_120m(clk_120m), .ttagres(ttagres),
		.pps(pps), .evtclkf(evtclkf), .evtclks(evtclks), .dead(dead),
		.evtcnt(evtcnt), .evtcntm(evtcntm),
		.address_wsb(address_wsb), .address_rsb(address_rsb),
		.address_wmb(address_wmb), .address_rmb(address_rmb),
		.status_clr(status_clr), .teststatus(teststatus),
		.c120mout(c120mout), .c120calout(c120calout), .c120deadout(c120deadout),
		.onanosec(onanosec), .oseconds(oseconds),
		.c120mout_sb(c120mout_sb), .c120calout_sb(c120calout_sb),
		.slowtriggerns(slowtriggerns), .slowtriggersec(slowtriggersec),
		.c120mout_mb(c120mout_mb), .c120calout_mb(c120calout_mb)
	);

	always @(posedge clk_120m) cycle_cnt <= cycle_cnt + 1;

	// compare process, drains on the rising edge what the stimulus queued on the falling edge
	always @(posedge clk_120m) begin
		while (exp_q.size() > 0) begin
			chk_act  = act_q.pop_front();
			chk_exp  = exp_q.pop_front();
			chk_what = what_q.pop_front();
			assert (chk_act === chk_exp) else begin
				error_cnt++;
				$display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
					$time, chk_what, chk_act, chk_exp);
			end
		end
	end

	// expected ns word: tag on top, bit 27 low, cycle count moved on by delta from base
	function automatic ttag_word_t ref_ns_word(input tag_t t, input ttag_word_t base,
			input int delta);
		ns_count_t ns;
		ns = base[NS_W-1:0] + ns_count_t'(delta);
		return {t, 1'b0, ns};
	endfunction

	// expected cycle-count word delta cycles after prev, zero-extended
	function automatic ttag_word_t ref_count_word(input ttag_word_t prev, input int delta);
		ns_count_t cnt;
		cnt = prev[NS_W-1:0] + ns_count_t'(delta);
		return ttag_word_t'(cnt);
	endfunction

	function automatic ttag_word_t ref_sec_word(input int n_pps);
		return ttag_word_t'(sec_count_t'(n_pps)); // one second per pps
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge clk_120m);
	endtask

	task automatic push_check(input ttag_word_t act, input ttag_word_t exp, input string what);
		act_q.push_back(act);
		exp_q.push_back(exp);
		what_q.push_back(what);
	endtask

	task automatic set_line(input status_bit_e b, input logic v);
		case (b)
			STAT_SLOW: evtclks = v;
			STAT_PPS:  pps     = v;
			STAT_FAST: evtclkf = v;
			STAT_DEAD: dead    = v;
		endcase
	endtask

	task automatic pulse_line(input status_bit_e b, input int width);
		set_line(b, 1'b1);
		idle(width); // line high for exactly width cycles
		set_line(b, 1'b0);
	endtask

	task automatic wait_status(input status_bit_e b, input logic level, input int max_cycles);
		int n;
		n = 0;
		while (teststatus[b] !== level && timeout_cnt == 0) begin
			@(negedge clk_120m);
			n++;
			if (n > max_cycles) begin
				timeout_cnt++;
				$display("timeout at %0t ns: status bit %0d never went to %0b", $time, b, level);
			end
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (ttagres !== 1'b0 && timeout_cnt == 0) begin
			@(negedge clk_120m);
			n++;
			if (n > 40) begin
				timeout_cnt++;
				$display("timeout at %0t ns: reset was never released", $time);
			end
		end
	endtask

	task automatic clear_status(input status_bit_e b);
		status_clr[b] = 1'b1;
		wait_status(b, 1'b0, 16);
		status_clr[b] = 1'b0;
		idle(3); // synchronized clear drops before the next event
	endtask

	task automatic read_slot(input logic slow, input int s, output ttag_word_t ns_w,
			output ttag_word_t sec_w, output ttag_word_t mout_w, output ttag_word_t cal_w);
		if (slow) address_rmb = SLOT_W'(s);
		else address_rsb = SLOT_W'(s);
		@(negedge clk_120m); // combinational read, settled a half period later
		ns_w   = slow ? slowtriggerns  : onanosec;
		sec_w  = slow ? slowtriggersec : oseconds;
		mout_w = slow ? c120mout_mb    : c120mout_sb;
		cal_w  = slow ? c120calout_mb  : c120calout_sb;
	endtask

	task automatic check_reset_state();
		ttag_word_t a, b, c, d;
		push_check(teststatus, '0, "teststatus after reset");
		push_check(c120mout, '0, "c120mout after reset");
		push_check(c120calout, '0, "c120calout after reset");
		push_check(c120deadout, '0, "c120deadout after reset");
		for (int st = 0; st < 2; st++) begin
			for (int s = 0; s < NUM_SLOTS; s++) begin
				read_slot(st == 1, s, a, b, c, d);
				push_check(a | b | c | d, '0, $sformatf("buffer %0d slot %0d after reset", st, s));
			end
		end
	endtask

	task automatic run_calibration();
		int spacing, raise, prev_raise;
		ttag_word_t prev_mout;
		prev_raise = 0;
		prev_mout  = '0;
		for (int k = 0; k < 6; k++) begin
			spacing = 40 + ($random(seed) & 127);
			if (k > 0) idle(prev_raise + spacing - cycle_cnt);
			raise = cycle_cnt;
			pulse_line(STAT_PPS, 3);
			pps_count++;
			wait_status(STAT_PPS, 1'b1, 16);
			if (k > 0) begin // first capture has no previous pps to measure from
				push_check(c120calout, ref_count_word('0, raise - prev_raise),
					$sformatf("c120calout after pps %0d", k));
				push_check(c120mout, ref_count_word(prev_mout, raise - prev_raise),
					$sformatf("c120mout step after pps %0d", k));
			end
			prev_mout  = c120mout;
			prev_raise = raise;
			clear_status(STAT_PPS);
		end
	endtask

	task automatic fill_buffer(input logic slow);
		status_bit_e b;
		tag_t        t;
		int          st;
		st = slow ? 1 : 0;
		if (slow) b = STAT_SLOW;
		else b = STAT_FAST;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			t = tag_t'($random(seed));
			rec_tag[st][s] = t;
			if (slow) begin
				evtcntm     = t;
				address_wmb = SLOT_W'(s); // held until the next trigger
			end else begin
				evtcnt      = t;
				address_wsb = SLOT_W'(s);
			end
			rec_cycle[st][s] = cycle_cnt;
			pulse_line(b, 2);
			wait_status(b, 1'b1, 16);
			rec_sec[st][s]  = ref_sec_word(pps_count);
			rec_mout[st][s] = c120mout; // no pps here, captures are steady
			rec_cal[st][s]  = c120calout;
			clear_status(b);
			idle($random(seed) & 15); // random extra gap
		end
	endtask

	task automatic check_buffer(input logic slow);
		ttag_word_t ns_w, sec_w, mout_w, cal_w;
		int         st;
		string      side;
		st   = slow ? 1 : 0;
		side = slow ? "muon" : "shower";
		for (int s = 0; s < NUM_SLOTS; s++) begin
			read_slot(slow, s, ns_w, sec_w, mout_w, cal_w);
			if (s == 0 && !base_valid[st]) begin
				ns_base[st]    = ns_w;
				base_valid[st] = 1'b1;
			end
			push_check(ns_w, ref_ns_word(rec_tag[st][s], ns_base[st],
				rec_cycle[st][s] - rec_cycle[st][0]), $sformatf("%s slot %0d ns", side, s));
			push_check(sec_w, rec_sec[st][s], $sformatf("%s slot %0d seconds", side, s));
			push_check(mout_w, rec_mout[st][s], $sformatf("%s slot %0d mout", side, s));
			push_check(cal_w, rec_cal[st][s], $sformatf("%s slot %0d calout", side, s));
		end
	endtask

	task automatic run_dead_time();
		int width;
		for (int k = 0; k < 4; k++) begin
			width = 3 + ($random(seed) & 31);
			pulse_line(STAT_DEAD, width);
			wait_status(STAT_DEAD, 1'b1, 16);
			push_check(c120deadout, ref_count_word('0, width), $sformatf("dead width %0d", width));
			clear_status(STAT_DEAD);
		end
	endtask

	task automatic run_status_check();
		status_bit_e b;
		status_vec_t mask;
		mask = '0;
		for (int i = 0; i < STAT_N; i++) begin // set every flag in turn
			b = status_bit_e'(i);
			pulse_line(b, 3);
			wait_status(b, 1'b1, 16);
			mask[b] = 1'b1;
			push_check(teststatus, ttag_word_t'(mask), $sformatf("status set bit %0d", i));
		end
		for (int i = 0; i < STAT_N; i++) begin // clear them one by one
			b = status_bit_e'(i);
			clear_status(b);
			mask[b] = 1'b0;
			push_check(teststatus, ttag_word_t'(mask), $sformatf("status clear bit %0d", i));
		end
	endtask

	initial begin
		pps         = 1'b0;
		evtclkf     = 1'b0;
		evtclks     = 1'b0;
		dead        = 1'b0;
		evtcnt      = '0;
		evtcntm     = '0;
		address_wsb = '0;
		address_rsb = '0;
		address_wmb = '0;
		address_rmb = '0;
		status_clr  = '0;
		base_valid  = '{1'b0, 1'b0};
		wait_reset_release();
		idle(2);
		check_reset_state();
		run_calibration();
		fill_buffer(1'b0);
		check_buffer(1'b0);
		fill_buffer(1'b1);
		check_buffer(1'b1);
		check_buffer(1'b0); // shower records must survive the muon writes
		run_dead_time();
		run_status_check();
		idle(4); // let the compare process drain
		$display("errors: %0d, timeouts: %0d", error_cnt, timeout_cnt);
		if (error_cnt == 0 && timeout_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- ttag_ctrl_pkg.sv
// status bit positions and the clear/status vector type used by the sync and status blocks
`default_nettype none

package ttag_ctrl_pkg;

	localparam int STAT_N = 4; // number of sticky event flags

	// bit position of each event flag in teststatus and in status_clr
	typedef enum logic [1:0] {
		STAT_SLOW = 2'd0, // slow (muon) trigger seen
		STAT_PPS  = 2'd1, // pps edge seen
		STAT_FAST = 2'd2, // fast (shower) trigger seen
		STAT_DEAD = 2'd3  // end of dead period seen
	} status_bit_e;

	typedef logic [STAT_N-1:0] status_vec_t; // clear bits in, status bits out

endpackage

`default_nettype wire

//--- ttag_dead_timer.sv
// measures each dead period in clock cycles and holds the last width for readout
`timescale 1ns/1ps
`default_nettype none

module ttag_dead_timer import ttag_time_pkg::*; (
	input  logic       clk_120m,    // 120 MHz system clock
	input  logic       ttagres,     // async reset, active high
	input  logic       dead_sync,   // synchronized dead level
	input  logic       dead_end_stb,// falling edge of dead
	output ttag_word_t c120deadout  // width of the last dead period
);

	ns_count_t dead_cnt; // cycles spent dead so far
	ns_count_t dead_q;   // pipeline register, lines the count up with the end strobe

	always_ff @(posedge clk_120m or posedge ttagres) begin
		if (ttagres) begin
			dead_cnt    <= '0;
			dead_q      <= '0;
			c120deadout <= '0;
		end else begin
			if (dead_sync) begin
				dead_cnt <= dead_cnt + 1'b1;
			end else begin
				dead_cnt <= '0; // idle between dead periods
			end
			dead_q <= dead_cnt;
			if (dead_end_stb) begin
				c120deadout <= {{NS_PAD{1'b0}}, dead_q}; // final width still in dead_q here
			end
		end
	end

endmodule

`default_nettype wire

//--- ttag_event_buffer.sv
// trigger time buffer: registered slot decode, four-word records per slot and a read mux
`timescale 1ns/1ps
`default_nettype none

module ttag_event_buffer import ttag_time_pkg::*; #(
	parameter int NUM_SLOTS = 4 // buffer depth
) (
	input  logic                         clk_120m,   // 120 MHz system clock
	input  logic                         ttagres,    // async reset, active high
	input  logic                         trig_stb,   // trigger edge, one cycle
	input  tag_t                         tag,        // trigger memory tag
	input  logic [$clog2(NUM_SLOTS)-1:0] wr_slot,    // slot to write on the next trigger
	input  logic [$clog2(NUM_SLOTS)-1:0] rd_slot,    // slot shown at the outputs
	input  ns_count_t                    ns_now,     // current cycle count
	input  sec_count_t                   sec_now,    // current seconds
	input  ttag_word_t                   c120mout,   // cycle count at last pps
	input  ttag_word_t                   c120calout, // calibration at last pps
	output ttag_word_t                   rd_ns,      // tag, zero bit and cycle count
	output ttag_word_t                   rd_sec,     // seconds, zero-extended
	output ttag_word_t                   rd_mout,    // c120mout at trigger time
	output ttag_word_t                   rd_calout   // c120calout at trigger time
);

	logic [NUM_SLOTS-1:0] wr_ena;   // one-hot slot enable, one cycle behind wr_slot
	ttag_word_t           ns_word;  // packed ns field for the incoming record
	ttag_word_t           sec_word; // packed seconds field

	ttag_word_t rec_ns    [NUM_SLOTS]; // per-slot records
	ttag_word_t rec_sec   [NUM_SLOTS];
	ttag_word_t rec_mout  [NUM_SLOTS];
	ttag_word_t rec_calout[NUM_SLOTS];

	assign ns_word  = {tag, 1'b0, ns_now};          // tag in [31:28], bit 27 held low
	assign sec_word = {{SEC_PAD{1'b0}}, sec_now};

	// write address decoder
	always_ff @(posedge clk_120m or posedge ttagres) begin
		if (ttagres) begin
			wr_ena <= '0;
		end else begin
			wr_ena <= {{(NUM_SLOTS-1){1'b0}}, 1'b1} << wr_slot;
		end
	end

	// slot records, the whole record lands in one cycle
	always_ff @(posedge clk_120m or posedge ttagres) begin
		if (ttagres) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				rec_ns[i]     <= '0;
				rec_sec[i]    <= '0;
				rec_mout[i]   <= '0;
				rec_calout[i] <= '0;
			end
		end else if (trig_stb) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				if (wr_ena[i]) begin // overwrite, no back-pressure
					rec_ns[i]     <= ns_word;
					rec_sec[i]    <= sec_word;
					rec_mout[i]   <= c120mout;
					rec_calout[i] <= c120calout;
				end
			end
		end
	end

	// combinational read
	assign rd_ns     = rec_ns[rd_slot];
	assign rd_sec    = rec_sec[rd_slot];
	assign rd_mout   = rec_mout[rd_slot];
	assign rd_calout = rec_calout[rd_slot];

endmodule

`default_nettype wire

//--- ttag_status.sv
// sticky test-status flags for pps, triggers and dead end, each with its own clear bit
`timescale 1ns/1ps
`default_nettype none

module ttag_status import ttag_time_pkg::*; import ttag_ctrl_pkg::*; (
	input  logic        clk_120m,     // 120 MHz system clock
	input  logic        ttagres,      // async reset, active high
	input  logic        pps_stb,      // pps edge
	input  logic        fast_stb,     // fast trigger edge
	input  logic        slow_stb,     // slow trigger edge
	input  logic        dead_end_stb, // end of dead period
	input  status_vec_t clr_sync,     // synchronized clear bits
	output ttag_word_t  teststatus    // flags in the low bits
);

	status_vec_t stat_set; // events seen this cycle, by flag position
	status_vec_t stat_q;   // sticky flags

	assign stat_set[STAT_SLOW] = slow_stb;
	assign stat_set[STAT_PPS]  = pps_stb;
	assign stat_set[STAT_FAST] = fast_stb;
	assign stat_set[STAT_DEAD] = dead_end_stb;

	always_ff @(posedge clk_120m or posedge ttagres) begin
		if (ttagres) begin
			stat_q <= '0;
		end else begin
			stat_q <= (stat_q | stat_set) & ~clr_sync; // a held clear wins over a new event
		end
	end

	assign teststatus = {{($bits(ttag_word_t) - STAT_N){1'b0}}, stat_q};

endmodule

`default_nettype wire

//--- ttag_sync.sv
// brings pps, triggers, dead and clear bits into clk_120m and makes one-cycle edge strobes
`timescale 1ns/1ps
`default_nettype none

module ttag_sync import ttag_ctrl_pkg::*; (
	input  logic        clk_120m,     // 120 MHz system clock
	input  logic        ttagres,      // async reset, active high
	input  logic        pps,          // gps pulse per second
	input  logic        evtclkf,      // fast trigger
	input  logic        evtclks,      // slow trigger
	input  logic        dead,         // dead time level
	input  status_vec_t status_clr,   // clear bits from the processor side
	output logic        pps_stb,      // pps rising edge, one cycle
	output logic        fast_stb,     // fast trigger rising edge
	output logic        slow_stb,     // slow trigger rising edge
	output logic        dead_sync,    // synchronized dead level
	output logic        dead_end_stb, // dead falling edge, one cycle
	output status_vec_t clr_sync      // synchronized clear bits
);

	// channel positions in the packed input vector
	localparam int CH_PPS  = 0;
	localparam int CH_FAST = 1;
	localparam int CH_SLOW = 2;
	localparam int CH_DEAD = 3;
	localparam logic [3:0] FALL_MASK = 4'b1000; // dead is detected on its falling edge

	logic [3:0] raw_in; // async inputs packed together
	(* ASYNC_REG = "TRUE" *) logic [3:0] in_meta;        // first sync stage
	(* ASYNC_REG = "TRUE" *) logic [3:0] in_sync;        // second sync stage
	(* ASYNC_REG = "TRUE" *) status_vec_t clr_meta;      // clear bits, first stage
	(* ASYNC_REG = "TRUE" *) status_vec_t clr_sync_q;    // clear bits, second stage
	logic [3:0] in_dly; // previous synchronized value for edge compare
	logic [3:0] stb_q;  // registered edge strobes

	assign raw_in = {dead, evtclks, evtclkf, pps};

	always_ff @(posedge clk_120m or posedge ttagres) begin
		if (ttagres) begin
			in_meta    <= '0;
			in_sync    <= '0;
			in_dly     <= '0;
			stb_q      <= '0;
			clr_meta   <= '0;
			clr_sync_q <= '0;
		end else begin
			in_meta    <= raw_in;
			in_sync    <= in_meta;
			in_dly     <= in_sync;
			// flip the falling-edge channels so one rising compare serves all
			stb_q      <= (in_sync ^ FALL_MASK) & ~(in_dly ^ FALL_MASK);
			clr_meta   <= status_clr;
			clr_sync_q <= clr_meta; // two cycles behind status_clr
		end
	end

	assign pps_stb      = stb_q[CH_PPS];
	assign fast_stb     = stb_q[CH_FAST];
	assign slow_stb     = stb_q[CH_SLOW];
	assign dead_end_stb = stb_q[CH_DEAD];
	assign dead_sync    = in_sync[CH_DEAD]; // level for the dead counter
	assign clr_sync     = clr_sync_q;

endmodule

`default_nettype wire

//--- ttag_time_pkg.sv
// time word widths and types shared by the counters, event buffers and top of the time tagger
`default_nettype none

package ttag_time_pkg;

	localparam int NS_W  = 27; // free-running clock-cycle counter, wraps above one second at 120 MHz
	localparam int SEC_W = 28; // pps seconds counter
	localparam int TAG_W = 4;  // trigger memory tag carried in the ns word

	typedef logic [NS_W-1:0]  ns_count_t;  // cycle count value
	typedef logic [SEC_W-1:0] sec_count_t; // seconds count value
	typedef logic [TAG_W-1:0] tag_t;       // trigger memory tag
	typedef logic [31:0]      ttag_word_t; // processor-visible register word

	// padding from a counter value up to a full register word
	localparam int NS_PAD  = $bits(ttag_word_t) - NS_W;
	localparam int SEC_PAD = $bits(ttag_word_t) - SEC_W;

endpackage

`default_nettype wire

//--- ttag_timebase.sv
// free-running cycle count, pps seconds and oscillator calibration with pps capture registers
`timescale 1ns/1ps
`default_nettype none

module ttag_timebase import ttag_time_pkg::*; (
	input  logic       clk_120m,  // 120 MHz system clock
	input  logic       ttagres,   // async reset, active high
	input  logic       pps_stb,   // synchronized pps edge
	output ns_count_t  ns_now,    // registered cycle count
	output sec_count_t sec_now,   // registered seconds count
	output ttag_word_t c120mout,  // cycle count latched at pps
	output ttag_word_t c120calout // cycles per second latched at pps
);

	// restart value of the calibration counter; the counter and its pipeline
	// register together lag the strobe by two cycles, so starting at 2 makes
	// the captured value the full pps-to-pps spacing
	localparam ns_count_t CAL_LOAD = ns_count_t'(2);

	ns_count_t  ns_cnt;  // nanosecond (cycle) counter
	sec_count_t sec_cnt; // seconds counter
	ns_count_t  cal_cnt; // calibration counter, restarted by pps
	ns_count_t  cal_q;   // calibration pipeline register

	always_ff @(posedge clk_120m or posedge ttagres) begin
		if (ttagres) begin
			ns_cnt     <= '0;
			ns_now     <= '0;
			sec_cnt    <= '0;
			sec_now    <= '0;
			cal_cnt    <= '0;
			cal_q      <= '0;
			c120mout   <= '0;
			c120calout <= '0;
		end else begin
			ns_cnt  <= ns_cnt + 1'b1; // wraps at 2**NS_W
			ns_now  <= ns_cnt;
			if (pps_stb) begin
				sec_cnt <= sec_cnt + 1'b1; // one second per pps
			end
			sec_now <= sec_cnt;
			if (pps_stb) begin
				cal_cnt <= CAL_LOAD;
			end else begin
				cal_cnt <= cal_cnt + 1'b1;
			end
			cal_q <= cal_cnt;
			if (pps_stb) begin
				c120mout   <= {{NS_PAD{1'b0}}, ns_now}; // clock phase at pps
				c120calout <= {{NS_PAD{1'b0}}, cal_q};  // cycles in the last second
			end
		end
	end

endmodule

`default_nettype wire

//--- ttag_top.f
ttag_time_pkg.sv
ttag_ctrl_pkg.sv
ttag_sync.sv
ttag_timebase.sv
ttag_event_buffer.sv
ttag_dead_timer.sv
ttag_status.sv
ttag_top.sv
tb_ttag_clkgen.sv
tb_ttag_top.sv

//--- ttag_top.sv
// time tagger top: sync, timebase, shower and muon buffers, dead timer and status
`timescale 1ns/1ps
`default_nettype none

module ttag_top import ttag_time_pkg::*; import ttag_ctrl_pkg::*; #(
	parameter int NUM_SLOTS = 4 // depth of both trigger buffers
) (
	input  logic                         clk_120m,       // 120 MHz system clock
	input  logic                         ttagres,        // async reset, active high
	input  logic                         pps,            // gps pulse per second
	input  logic                         evtclkf,        // fast (shower) trigger
	input  logic                         evtclks,        // slow (muon) trigger
	input  logic                         dead,           // dead time level
	input  tag_t                         evtcnt,         // shower tag from trigger memory
	input  tag_t                         evtcntm,        // muon tag from trigger memory
	input  logic [$clog2(NUM_SLOTS)-1:0] address_wsb,    // shower write slot
	input  logic [$clog2(NUM_SLOTS)-1:0] address_rsb,    // shower read slot
	input  logic [$clog2(NUM_SLOTS)-1:0] address_wmb,    // muon write slot
	input  logic [$clog2(NUM_SLOTS)-1:0] address_rmb,    // muon read slot
	input  status_vec_t                  status_clr,     // status clear bits
	output ttag_word_t                   teststatus,     // sticky event flags
	output ttag_word_t                   c120mout,       // cycle count at pps
	output ttag_word_t                   c120calout,     // cycles per second
	output ttag_word_t                   c120deadout,    // last dead width
	output ttag_word_t                   onanosec,       // shower ns word
	output ttag_word_t                   oseconds,       // shower seconds
	output ttag_word_t                   c120mout_sb,    // shower c120mout copy
	output ttag_word_t                   c120calout_sb,  // shower c120calout copy
	output ttag_word_t                   slowtriggerns,  // muon ns word
	output ttag_word_t                   slowtriggersec, // muon seconds
	output ttag_word_t                   c120mout_mb,    // muon c120mout copy
	output ttag_word_t                   c120calout_mb   // muon c120calout copy
);

	logic        pps_stb;      // strobes from the sync block
	logic        fast_stb;
	logic        slow_stb;
	logic        dead_end_stb;
	logic        dead_sync;
	status_vec_t clr_sync;
	ns_count_t   ns_now;       // timebase to buffers
	sec_count_t  sec_now;

	ttag_sync i_sync (
		.clk_120m(clk_120m), .ttagres(ttagres),
		.pps(pps), .evtclkf(evtclkf), .evtclks(evtclks), .dead(dead),
		.status_clr(status_clr),
		.pps_stb(pps_stb), .fast_stb(fast_stb), .slow_stb(slow_stb),
		.dead_sync(dead_sync), .dead_end_stb(dead_end_stb), .clr_sync(clr_sync)
	);

	ttag_timebase i_timebase (
		.clk_120m(clk_120m), .ttagres(ttagres), .pps_stb(pps_stb),
		.ns_now(ns_now), .sec_now(sec_now),
		.c120mout(c120mout), .c120calout(c120calout)
	);

	ttag_event_buffer #(.NUM_SLOTS(NUM_SLOTS)) i_shower_buf ( // written on fast trigger
		.clk_120m(clk_120m), .ttagres(ttagres), .trig_stb(fast_stb), .tag(evtcnt),
		.wr_slot(address_wsb), .rd_slot(address_rsb),
		.ns_now(ns_now), .sec_now(sec_now), .c120mout(c120mout), .c120calout(c120calout),
		.rd_ns(onanosec), .rd_sec(oseconds),
		.rd_mout(c120mout_sb), .rd_calout(c120calout_sb)
	);

	ttag_event_buffer #(.NUM_SLOTS(NUM_SLOTS)) i_muon_buf ( // written on slow trigger
		.clk_120m(clk_120m), .ttagres(ttagres), .trig_stb(slow_stb), .tag(evtcntm),
		.wr_slot(address_wmb), .rd_slot(address_rmb),
		.ns_now(ns_now), .sec_now(sec_now), .c120mout(c120mout), .c120calout(c120calout),
		.rd_ns(slowtriggerns), .rd_sec(slowtriggersec),
		.rd_mout(c120mout_mb), .rd_calout(c120calout_mb)
	);

	ttag_dead_timer i_dead_timer (
		.clk_120m(clk_120m), .ttagres(ttagres),
		.dead_sync(dead_sync), .dead_end_stb(dead_end_stb), .c120deadout(c120deadout)
	);

	ttag_status i_status (
		.clk_120m(clk_120m), .ttagres(ttagres),
		.pps_stb(pps_stb), .fast_stb(fast_stb), .slow_stb(slow_stb),
		.dead_end_stb(dead_end_stb), .clr_sync(clr_sync), .teststatus(teststatus)
	);

endmodule

`default_nettype wire
